/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

	// datapath and address width
	localparam int XLEN = 32;

	// first fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h80000000;

	// major opcodes of the executed set
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// only system word that is accepted
	localparam logic [31:0] EBREAK_WORD = 32'h00100073;

	// alu operation codes
	localparam logic [3:0] ALU_ADD    = 4'd0;
	localparam logic [3:0] ALU_SUB    = 4'd1;
	localparam logic [3:0] ALU_SLL    = 4'd2;
	localparam logic [3:0] ALU_SLT    = 4'd3;
	localparam logic [3:0] ALU_SLTU   = 4'd4;
	localparam logic [3:0] ALU_XOR    = 4'd5;
	localparam logic [3:0] ALU_SRL    = 4'd6;
	localparam logic [3:0] ALU_SRA    = 4'd7;
	localparam logic [3:0] ALU_OR     = 4'd8;
	localparam logic [3:0] ALU_AND    = 4'd9;
	// operand b straight through, used by lui
	localparam logic [3:0] ALU_PASS_B = 4'd10;

	// r-format view, also carries the j immediate bits
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	// i-format view
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_i_t;

	// u-format view
	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_u_t;

	// one fetched word, three ways of reading it
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
		inst_u_t u;
	} inst_u;

	// decoder to execute
	typedef struct packed {
		logic [3:0]      alu_op;
		logic            src_a_pc;
		logic            src_b_imm;
		logic            is_jump;
		logic            jump_reg;
		logic            wen;
		logic [4:0]      rd;
		logic [XLEN-1:0] imm;
	} dec_ctrl_t;

	// retire trace entry
	typedef struct packed {
		logic            valid;
		logic [4:0]      rd;
		logic [XLEN-1:0] data;
	} commit_t;

endpackage

`default_nettype wire

/* hdl/pc_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_reg (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [core_pkg::XLEN-1:0] next_pc_i,
	input  logic                      halt_i,
	output logic [core_pkg::XLEN-1:0] pc_o,
	output logic                      halted_o
);

	// one instruction retires per edge
	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_o     <= core_pkg::RESET_PC;
			halted_o <= 1'b0;
		end else if (!halted_o) begin
			if (halt_i) begin
				// ebreak retiring so the pc parks on it
				halted_o <= 1'b1;
			end else begin
				pc_o <= next_pc_i;
			end
		end
	end

	// fetch address must stay word aligned
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst)
		pc_o[1:0] == 2'b00
	);

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module regfile (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [4:0]                raddr1_i,
	input  logic [4:0]                raddr2_i,
	input  logic                      wen_i,
	input  logic [4:0]                waddr_i,
	input  logic [core_pkg::XLEN-1:0] wdata_i,
	output logic [core_pkg::XLEN-1:0] rdata1_o,
	output logic [core_pkg::XLEN-1:0] rdata2_o
);

	// x0 has a slot that is never written
	logic [core_pkg::XLEN-1:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && (waddr_i != 5'd0)) begin
			// writes to x0 just fall away
			regs[waddr_i] <= wdata_i;
		end
	end

	// combinational reads
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

	// x0 reads as zero on both ports
	a_x0_zero: assert property (
		@(posedge clk) disable iff (!rst)
		((raddr1_i != 5'd0) || (rdata1_o == '0)) &&
		((raddr2_i != 5'd0) || (rdata2_o == '0))
	);

endmodule

`default_nettype wire

/* decode/decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module decoder (
	input  core_pkg::inst_u     inst_i,
	output logic [4:0]          rs1_o,
	output logic [4:0]          rs2_o,
	output core_pkg::dec_ctrl_t ctrl_o,
	output logic                invalid_o,
	output logic                ebreak_o
);

	logic [core_pkg::XLEN-1:0] imm_i_type;
	logic [core_pkg::XLEN-1:0] imm_u_type;
	logic [core_pkg::XLEN-1:0] imm_j_type;
	logic                      legal;
	// funct7 of plain and alternate forms
	logic                      f7_zero;
	logic                      f7_alt;

	// funct3 to alu op with alt picking sub or sra
	function automatic logic [3:0] alu_from_funct3(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000: alu_from_funct3 = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			3'b001: alu_from_funct3 = core_pkg::ALU_SLL;
			3'b010: alu_from_funct3 = core_pkg::ALU_SLT;
			3'b011: alu_from_funct3 = core_pkg::ALU_SLTU;
			3'b100: alu_from_funct3 = core_pkg::ALU_XOR;
			3'b101: alu_from_funct3 = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			3'b110: alu_from_funct3 = core_pkg::ALU_OR;
			default: alu_from_funct3 = core_pkg::ALU_AND;
		endcase
	endfunction

	// register addresses sit at fixed bits
	assign rs1_o = inst_i.r.rs1;
	assign rs2_o = inst_i.r.rs2;

	// sign extended i immediate
	assign imm_i_type = {{20{inst_i.i.imm12[11]}}, inst_i.i.imm12};
	assign imm_u_type = {inst_i.u.imm20, 12'b0};
	// j immediate gathered from the r view fields
	assign imm_j_type = {{12{inst_i.r.funct7[6]}}, inst_i.r.rs1, inst_i.r.funct3,
		inst_i.r.rs2[0], inst_i.r.funct7[5:0], inst_i.r.rs2[4:1], 1'b0};

	assign f7_zero = (inst_i.r.funct7 == 7'b0000000);
	assign f7_alt  = (inst_i.r.funct7 == 7'b0100000);

	assign ebreak_o = (inst_i == core_pkg::EBREAK_WORD);

	always_comb begin
		ctrl_o    = '0;
		ctrl_o.rd = inst_i.r.rd;
		legal     = 1'b0;
		case (inst_i.r.opcode)
			core_pkg::OPC_OP_IMM: begin
				ctrl_o.alu_op    = alu_from_funct3(inst_i.i.funct3,
					(inst_i.i.funct3 == 3'b101) & inst_i.r.funct7[5]);
				ctrl_o.src_b_imm = 1'b1;
				ctrl_o.imm       = imm_i_type;
				ctrl_o.wen       = 1'b1;
				// shift amounts leave funct7 for the shift kind
				case (inst_i.i.funct3)
					3'b001:  legal = f7_zero;
					3'b101:  legal = f7_zero | f7_alt;
					default: legal = 1'b1;
				endcase
			end
			core_pkg::OPC_OP: begin
				ctrl_o.alu_op = alu_from_funct3(inst_i.r.funct3, inst_i.r.funct7[5]);
				ctrl_o.wen    = 1'b1;
				// alternate funct7 only for sub and sra
				legal = f7_zero |
					(f7_alt & ((inst_i.r.funct3 == 3'b000) | (inst_i.r.funct3 == 3'b101)));
			end
			core_pkg::OPC_LUI: begin
				ctrl_o.alu_op    = core_pkg::ALU_PASS_B;
				ctrl_o.src_b_imm = 1'b1;
				ctrl_o.imm       = imm_u_type;
				ctrl_o.wen       = 1'b1;
				legal            = 1'b1;
			end
			core_pkg::OPC_AUIPC: begin
				ctrl_o.alu_op    = core_pkg::ALU_ADD;
				ctrl_o.src_a_pc  = 1'b1;
				ctrl_o.src_b_imm = 1'b1;
				ctrl_o.imm       = imm_u_type;
				ctrl_o.wen       = 1'b1;
				legal            = 1'b1;
			end
			core_pkg::OPC_JAL: begin
				// link value comes from execute
				ctrl_o.is_jump = 1'b1;
				ctrl_o.imm     = imm_j_type;
				ctrl_o.wen     = 1'b1;
				legal          = 1'b1;
			end
			core_pkg::OPC_JALR: begin
				ctrl_o.is_jump  = 1'b1;
				ctrl_o.jump_reg = 1'b1;
				ctrl_o.imm      = imm_i_type;
				ctrl_o.wen      = 1'b1;
				legal           = (inst_i.i.funct3 == 3'b000);
			end
			// ebreak writes nothing
			core_pkg::OPC_SYSTEM: legal = ebreak_o;
			default: legal = 1'b0;
		endcase
		// illegal word retires as a no-op
		if (!legal) begin
			ctrl_o.wen     = 1'b0;
			ctrl_o.is_jump = 1'b0;
		end
		invalid_o = ~legal;
	end

endmodule

`default_nettype wire

/* hdl/alu_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_exec (
	input  logic                      rst,
	input  logic                      halted_i,
	input  logic [core_pkg::XLEN-1:0] pc_i,
	input  core_pkg::dec_ctrl_t       ctrl_i,
	input  logic [core_pkg::XLEN-1:0] rs1_data_i,
	input  logic [core_pkg::XLEN-1:0] rs2_data_i,
	input  logic                      ebreak_i,
	output logic                      reg_wen_o,
	output logic [4:0]                reg_waddr_o,
	output logic [core_pkg::XLEN-1:0] reg_wdata_o,
	output logic [core_pkg::XLEN-1:0] next_pc_o,
	output logic                      halt_o,
	output core_pkg::commit_t         commit_o
);

	logic [core_pkg::XLEN-1:0] op_a;
	logic [core_pkg::XLEN-1:0] op_b;
	logic [core_pkg::XLEN-1:0] alu_res;
	logic [core_pkg::XLEN-1:0] pc_plus4;
	logic [core_pkg::XLEN-1:0] jump_target;

	// operand muxes
	assign op_a = ctrl_i.src_a_pc ? pc_i : rs1_data_i;
	assign op_b = ctrl_i.src_b_imm ? ctrl_i.imm : rs2_data_i;

	always_comb begin
		case (ctrl_i.alu_op)
			core_pkg::ALU_ADD:    alu_res = op_a + op_b;
			core_pkg::ALU_SUB:    alu_res = op_a - op_b;
			core_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
			core_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			core_pkg::ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
			core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
			core_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
			core_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
			core_pkg::ALU_OR:     alu_res = op_a | op_b;
			core_pkg::ALU_AND:    alu_res = op_a & op_b;
			core_pkg::ALU_PASS_B: alu_res = op_b;
			default:              alu_res = '0;
		endcase
	end

	// sequential fetch address and link value
	assign pc_plus4 = pc_i + 32'd4;

	// jalr drops bit 0 of rs1 + imm
	assign jump_target = ctrl_i.jump_reg ?
		((rs1_data_i + ctrl_i.imm) & ~32'd1) : (pc_i + ctrl_i.imm);

	assign next_pc_o = ctrl_i.is_jump ? jump_target : pc_plus4;
	assign halt_o    = ebreak_i;

	// write-back blocked in reset and after halt
	assign reg_wen_o   = ctrl_i.wen & rst & ~halted_i;
	assign reg_waddr_o = ctrl_i.rd;
	assign reg_wdata_o = ctrl_i.is_jump ? pc_plus4 : alu_res;

	// trace shows only writes that land
	assign commit_o.valid = reg_wen_o & (ctrl_i.rd != 5'd0);
	assign commit_o.rd    = reg_waddr_o;
	assign commit_o.data  = reg_wdata_o;

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [core_pkg::XLEN-1:0] inst_i,
	output logic [core_pkg::XLEN-1:0] pc_o,
	output logic                      invalid_o,
	output logic                      halt_o,
	output core_pkg::commit_t         commit_o
);

	// decode side
	logic [4:0]                rs1_addr;
	logic [4:0]                rs2_addr;
	core_pkg::dec_ctrl_t       id_ctrl;
	logic                      id_ebreak;

	// register file read data
	logic [core_pkg::XLEN-1:0] rs1_data;
	logic [core_pkg::XLEN-1:0] rs2_data;

	// write-back and pc control
	logic                      wb_wen;
	logic [4:0]                wb_waddr;
	logic [core_pkg::XLEN-1:0] wb_wdata;
	logic [core_pkg::XLEN-1:0] next_pc;
	logic                      ex_halt;

	pc_reg i_pc_reg (
		.clk       (clk),
		.rst       (rst),
		.next_pc_i (next_pc),
		.halt_i    (ex_halt),
		.pc_o      (pc_o),
		.halted_o  (halt_o)
	);

	decoder i_decoder (
		.inst_i    (inst_i),
		.rs1_o     (rs1_addr),
		.rs2_o     (rs2_addr),
		.ctrl_o    (id_ctrl),
		.invalid_o (invalid_o),
		.ebreak_o  (id_ebreak)
	);

	regfile i_regfile (
		.clk      (clk),
		.rst      (rst),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.wen_i    (wb_wen),
		.waddr_i  (wb_waddr),
		.wdata_i  (wb_wdata),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	// execute and write-back in the same cycle
	alu_exec i_alu_exec (
		.rst         (rst),
		.halted_i    (halt_o),
		.pc_i        (pc_o),
		.ctrl_i      (id_ctrl),
		.rs1_data_i  (rs1_data),
		.rs2_data_i  (rs2_data),
		.ebreak_i    (id_ebreak),
		.reg_wen_o   (wb_wen),
		.reg_waddr_o (wb_waddr),
		.reg_wdata_o (wb_wdata),
		.next_pc_o   (next_pc),
		.halt_o      (ex_halt),
		.commit_o    (commit_o)
	);

endmodule

`default_nettype wire

/* bench/tb_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_core;

	localparam int CLK_PERIOD   = 100;
	// sample point 10 ns ahead of the next rising edge
	localparam int SAMPLE_DELAY = 90;
	localparam int RESET_CYCLES = 8;
	localparam int HALT_TIMEOUT = 20;
	localparam int HOLD_CYCLES  = 5;

	// one program step with its expected retire
	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		logic        invalid;
		logic        cvalid;
		logic [4:0]  rd;
		logic [31:0] data;
	} step_t;

	logic              clk;
	logic              rst;
	logic [31:0]       inst_i;
	logic [31:0]       pc_o;
	logic              invalid_o;
	logic              halt_o;
	core_pkg::commit_t commit_o;

	step_t       prog[$];
	logic [31:0] prog_pc;

	core_top i_core_top (
		.clk       (clk),
		.rst       (rst),
		.inst_i    (inst_i),
		.pc_o      (pc_o),
		.invalid_o (invalid_o),
		.halt_o    (halt_o),
		.commit_o  (commit_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm20);
		return {imm20, rd, opc};
	endfunction

	// j immediate bits are scattered over the word
	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::OPC_JAL};
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[ERROR] %s expected %h actual %h", sig, exp, act);
		$display("Result: FAILED");
		$fatal(1, "value mismatch on %s", sig);
	endtask

	// appends a step at the running program address
	task automatic add_step(input logic [31:0] inst, input logic invalid, input logic cvalid,
		input logic [4:0] rd, input logic [31:0] data);
		step_t s;
		s.inst    = inst;
		s.pc      = prog_pc;
		s.invalid = invalid;
		s.cvalid  = cvalid;
		s.rd      = rd;
		s.data    = data;
		prog.push_back(s);
		prog_pc = prog_pc + 32'd4;
	endtask

	task automatic build_program();
		// register-immediate ops where x1 = 5 and x2 = -3 feed later steps
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b000, 1, 0, 12'h005), 0, 1, 1, 32'h00000005);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b000, 2, 0, 12'hFFD), 0, 1, 2, 32'hFFFFFFFD);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b010, 3, 2, 12'h001), 0, 1, 3, 32'h00000001);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b011, 4, 2, 12'h001), 0, 1, 4, 32'h00000000);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b100, 5, 1, 12'hFFF), 0, 1, 5, 32'hFFFFFFFA);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b110, 6, 1, 12'h030), 0, 1, 6, 32'h00000035);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b111, 7, 2, 12'h0F0), 0, 1, 7, 32'h000000F0);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b001, 8, 1, 12'h004), 0, 1, 8, 32'h00000050);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b101, 9, 2, 12'h01C), 0, 1, 9, 32'h0000000F);
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b101, 10, 2, 12'h401), 0, 1, 10, 32'hFFFFFFFE);
		// write to x0 leaves no trace
		add_step(enc_i(core_pkg::OPC_OP_IMM, 3'b000, 0, 1, 12'h007), 0, 0, 0, 32'h0);
		// x0 still reads zero
		add_step(enc_r(7'h00, 3'b000, 11, 0, 1), 0, 1, 11, 32'h00000005);
		// register-register
		add_step(enc_r(7'h00, 3'b000, 12, 1, 2), 0, 1, 12, 32'h00000002);
		add_step(enc_r(7'h20, 3'b000, 13, 1, 2), 0, 1, 13, 32'h00000008);
		// shift amount 0x50 keeps only its low 5 bits
		add_step(enc_r(7'h00, 3'b001, 14, 1, 8), 0, 1, 14, 32'h00050000);
		add_step(enc_r(7'h00, 3'b010, 15, 2, 1), 0, 1, 15, 32'h00000001);
		add_step(enc_r(7'h00, 3'b011, 16, 2, 1), 0, 1, 16, 32'h00000000);
		add_step(enc_r(7'h00, 3'b100, 17, 1, 6), 0, 1, 17, 32'h00000030);
		add_step(enc_r(7'h00, 3'b101, 18, 2, 1), 0, 1, 18, 32'h07FFFFFF);
		add_step(enc_r(7'h20, 3'b101, 19, 2, 1), 0, 1, 19, 32'hFFFFFFFF);
		add_step(enc_r(7'h00, 3'b110, 20, 1, 7), 0, 1, 20, 32'h000000F5);
		add_step(enc_r(7'h00, 3'b111, 21, 2, 6), 0, 1, 21, 32'h00000035);
		// upper immediates with auipc at 0x8000005c
		add_step(enc_u(core_pkg::OPC_LUI, 22, 20'h12345), 0, 1, 22, 32'h12345000);
		add_step(enc_u(core_pkg::OPC_AUIPC, 23, 20'h00001), 0, 1, 23, 32'h8000105C);
		// jal from 0x80000060 lands at 0x80000080
		add_step(enc_j(24, 21'h00020), 0, 1, 24, 32'h80000064);
		prog_pc = 32'h80000080;
		// jalr 0x80000064 + 0x3d with bit 0 dropped
		add_step(enc_i(core_pkg::OPC_JALR, 3'b000, 25, 24, 12'h03D), 0, 1, 25, 32'h80000084);
		prog_pc = 32'h800000A0;
		// lw, beq and a mul style funct7 are all outside the set
		add_step(enc_i(7'b0000011, 3'b010, 1, 0, 12'h000), 1, 0, 0, 32'h0);
		add_step(32'h00108463, 1, 0, 0, 32'h0);
		add_step(enc_r(7'b0000001, 3'b000, 26, 1, 2), 1, 0, 0, 32'h0);
		// jalr with funct3 001 must fall through instead of jumping
		add_step(enc_i(core_pkg::OPC_JALR, 3'b001, 27, 24, 12'h010), 1, 0, 0, 32'h0);
		add_step(core_pkg::EBREAK_WORD, 0, 0, 0, 32'h0);
	endtask

	task automatic check_step(input step_t s);
		a_pc: assert (pc_o === s.pc) else report_mismatch("pc_o", s.pc, pc_o);
		a_inv: assert (invalid_o === s.invalid)
			else report_mismatch("invalid_o", {31'b0, s.invalid}, {31'b0, invalid_o});
		a_cv: assert (commit_o.valid === s.cvalid)
			else report_mismatch("commit_o.valid", {31'b0, s.cvalid}, {31'b0, commit_o.valid});
		if (s.cvalid) begin
			a_rd: assert (commit_o.rd === s.rd)
				else report_mismatch("commit_o.rd", {27'b0, s.rd}, {27'b0, commit_o.rd});
			a_data: assert (commit_o.data === s.data)
				else report_mismatch("commit_o.data", s.data, commit_o.data);
		end
	endtask

	initial begin
		int          cycles;
		logic [31:0] halt_pc;
		clk     = 1'b0;
		rst     = 1'b0;
		// addi x1 during reset would commit if reset did not gate it
		inst_i  = enc_i(core_pkg::OPC_OP_IMM, 3'b000, 1, 0, 12'h001);
		prog_pc = core_pkg::RESET_PC;
		build_program();
		halt_pc = prog[prog.size() - 1].pc;

		// nothing retires while in reset
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#(SAMPLE_DELAY);
			a_rst_cv: assert (commit_o.valid === 1'b0)
				else report_mismatch("commit_o.valid", 32'h0, {31'b0, commit_o.valid});
		end
		a_rst_pc: assert (pc_o === core_pkg::RESET_PC)
			else report_mismatch("pc_o", core_pkg::RESET_PC, pc_o);
		a_rst_halt: assert (halt_o === 1'b0)
			else report_mismatch("halt_o", 32'h0, {31'b0, halt_o});

		// fetch port model with one word per edge
		foreach (prog[i]) begin
			@(posedge clk);
			rst    <= 1'b1;
			inst_i <= prog[i].inst;
			#(SAMPLE_DELAY);
			check_step(prog[i]);
		end

		// ebreak retires on the next edge
		cycles = 0;
		while (halt_o !== 1'b1) begin
			if (cycles == HALT_TIMEOUT) begin
				$display("timeout: halt_o never rose after the ebreak step");
				$display("Result: FAILED");
				$fatal(1, "halt timeout");
			end else begin
				@(posedge clk);
				#(SAMPLE_DELAY);
				cycles++;
			end
		end

		// a legal addi after halt must stay silent
		repeat (HOLD_CYCLES) begin
			@(posedge clk);
			inst_i <= enc_i(core_pkg::OPC_OP_IMM, 3'b000, 5, 1, 12'h001);
			#(SAMPLE_DELAY);
			a_hold_pc: assert (pc_o === halt_pc) else report_mismatch("pc_o", halt_pc, pc_o);
			a_hold_halt: assert (halt_o === 1'b1)
				else report_mismatch("halt_o", 32'h1, {31'b0, halt_o});
			a_hold_cv: assert (commit_o.valid === 1'b0)
				else report_mismatch("commit_o.valid", 32'h0, {31'b0, commit_o.valid});
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
common/core_pkg.sv
hdl/pc_reg.sv
hdl/regfile.sv
decode/decoder.sv
hdl/alu_exec.sv
hdl/core_top.sv
bench/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_core -f flist.f -o sim_core

./obj_dir/sim_core
